// File: mext_core.f
mext_pkg.sv
mext_issue.sv
mext_mul_step.sv
mext_retire.sv
mext_regfile.sv
mext_core.sv
tb_mext_core.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0
TOP       ?= tb_mext_core
FILELIST  ?= mext_core.f
OBJ_DIR   ?= obj_dir
PASS_LINE := Result: PASSED

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_LINE)"

clean:
	rm -rf $(OBJ_DIR)

// File: mext_cases.txt
# T name | A reg value | M op rd rs1 rs2 | W cycles | R reg value
# Registers and cycles in decimal, values in hex, rand is random and * is the model value
T extremes
A 1 80000000
A 2 7fffffff
A 3 ffffffff
M MUL 10 2 2
M MULH 11 1 1
M MULH 12 1 2
M MULHSU 13 3 3
M MULHSU 14 1 1
M MULHU 15 3 3
M MULH 16 3 3
M MUL 17 1 3
M MULHU 18 1 0
R 10 00000001
R 11 40000000
R 12 c0000000
R 13 ffffffff
R 14 c0000000
R 15 fffffffe
R 16 00000000
R 17 80000000
R 18 00000000
T random
A 5 rand
A 6 rand
M MUL 20 5 6
M MULH 21 5 6
M MULHSU 22 5 6
M MULHU 23 6 5
R 20 *
R 23 *
T hazard
M MUL 7 2 3
M MULH 8 7 1
M MULHU 9 8 8
M MUL 30 3 9
R 8 3fffffff
R 9 0fffffff
R 30 f0000001
T wb_merge
M MUL 31 2 2
W 5
A 19 12345678
R 31 00000001
R 19 12345678
T x0
A 0 deadbeef
M MUL 0 1 3
M MULHU 16 0 0
R 0 00000000
R 16 00000000

// File: tb_mext_core.sv
`timescale 1ns/1ns
`default_nettype none

module tb_mext_core
    import mext_pkg::*;
();

    localparam int    NUM_STEPS    = 4;
    localparam int    HALF_PERIOD  = 50;
    localparam int    SAMPLE_DELAY = 20;
    localparam int    RESET_CYCLES = 8;
    localparam int    TOK_W        = 8 * 24;
    localparam string CASE_FILE    = "mext_cases.txt";

    // Model result waiting for its retire cycle
    typedef struct packed {
        reg_addr_t rd;
        word_t     data;
        int        accept_edge;
    } expect_t;

    logic      clk_i;
    logic      rst_i;
    logic      valid_i;
    mext_op_e  op_i;
    reg_addr_t rd_i;
    reg_addr_t rs1_i;
    reg_addr_t rs2_i;
    logic      stall_o;
    logic      alu_we_i;
    reg_addr_t alu_waddr_i;
    word_t     alu_wdata_i;
    logic      wb_stall_o;
    reg_addr_t rd_addr_i;
    word_t     rd_data_o;
    logic      result_valid_o;
    reg_addr_t result_rd_o;
    word_t     result_data_o;

    word_t     shadow [32];
    expect_t   exp_q [$];
    logic      retire_due;
    int        cycle;
    int        cycle_limit;
    int        checks;
    int        errors;
    int        test_checks;
    int        test_errors;
    int        test_count;
    string     test_name;

    mext_core #(
        .NUM_STEPS (NUM_STEPS)
    ) DUT (
        .clk_i          (clk_i),
        .rst_i          (rst_i),
        .valid_i        (valid_i),
        .op_i           (op_i),
        .rd_i           (rd_i),
        .rs1_i          (rs1_i),
        .rs2_i          (rs2_i),
        .stall_o        (stall_o),
        .alu_we_i       (alu_we_i),
        .alu_waddr_i    (alu_waddr_i),
        .alu_wdata_i    (alu_wdata_i),
        .wb_stall_o     (wb_stall_o),
        .rd_addr_i      (rd_addr_i),
        .rd_data_o      (rd_data_o),
        .result_valid_o (result_valid_o),
        .result_rd_o    (result_rd_o),
        .result_data_o  (result_data_o)
    );

    always #HALF_PERIOD clk_i = ~clk_i;

    always @(posedge clk_i) begin
        cycle = cycle + 1;
        if (cycle_limit > 0 && cycle > cycle_limit) begin
            $display("timeout: the case file did not finish within %0d cycles", cycle_limit);
            $display("Result: FAILED");
            $finish;
        end
    end

    // Retire order and timing follow from the accepting edge of each issue
    always @(negedge clk_i) begin
        check_retire();
    end

    ////////////////////////////////////////////////////////////////////////////
    // Checking helpers
    ////////////////////////////////////////////////////////////////////////////

    task automatic check_value(input string name, input word_t expected, input word_t actual);
        checks++;
        test_checks++;
        if (actual !== expected) begin
            errors++;
            test_errors++;
            $display("mismatch at %0t ns: %s expected %h actual %h",
                     $time, name, expected, actual);
        end
    endtask

    task automatic report_error(input string msg);
        errors++;
        test_errors++;
        $display("%s", msg);
    endtask

    task automatic check_retire();
        expect_t head;
        retire_due = exp_q.size() > 0 && exp_q[0].accept_edge + NUM_STEPS + 1 == cycle;
        if (retire_due || result_valid_o) begin
            check_value("result_valid_o", word_t'(retire_due), word_t'(result_valid_o));
        end
        if (retire_due) begin
            head = exp_q.pop_front();
            check_value("result_rd_o", word_t'(head.rd), word_t'(result_rd_o));
            check_value("result_data_o", head.data, result_data_o);
        end
    endtask

    // Exact 64-bit product of the extended operands
    function automatic word_t model_mul(input mext_op_e op, input word_t a, input word_t b);
        logic [63:0] a_wide;
        logic [63:0] b_wide;
        logic [63:0] product;
        a_wide  = (op == MULH || op == MULHSU) ? {{32{a[31]}}, a} : {32'b0, a};
        b_wide  = (op == MULH) ? {{32{b[31]}}, b} : {32'b0, b};
        product = a_wide * b_wide;
        return (op == MUL) ? product[31:0] : product[63:32];
    endfunction

    // Busy while the producer sits in the issue register or a step register
    function automatic logic source_busy(input reg_addr_t rs);
        logic busy;
        busy = 1'b0;
        foreach (exp_q[i]) begin
            if (rs != '0 && exp_q[i].rd == rs && cycle >= exp_q[i].accept_edge
                    && cycle <= exp_q[i].accept_edge + NUM_STEPS) begin
                busy = 1'b1;
            end
        end
        return busy;
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // Actions, each starts and ends on a falling edge
    ////////////////////////////////////////////////////////////////////////////

    task automatic issue_mul(input mext_op_e op, input reg_addr_t rd,
                             input reg_addr_t rs1, input reg_addr_t rs2);
        logic    accepted;
        expect_t entry;
        valid_i  = 1'b1;
        op_i     = op;
        rd_i     = rd;
        rs1_i    = rs1;
        rs2_i    = rs2;
        accepted = 1'b0;
        while (!accepted) begin
            #SAMPLE_DELAY;
            check_value("stall_o", word_t'(source_busy(rs1) || source_busy(rs2)),
                        word_t'(stall_o));
            accepted = !stall_o;
            if (accepted) begin
                entry.rd          = rd;
                entry.data        = model_mul(op, shadow[rs1], shadow[rs2]);
                entry.accept_edge = cycle + 1;
                exp_q.push_back(entry);
                if (rd != '0) begin
                    shadow[rd] = entry.data;
                end
            end
            @(negedge clk_i);
        end
        valid_i = 1'b0;
    endtask

    // Held until the first edge with the write port free
    task automatic alu_write(input reg_addr_t addr, input word_t data);
        logic held;
        alu_we_i    = 1'b1;
        alu_waddr_i = addr;
        alu_wdata_i = data;
        held        = 1'b1;
        while (held) begin
            #SAMPLE_DELAY;
            check_value("wb_stall_o", word_t'(retire_due), word_t'(wb_stall_o));
            held = wb_stall_o;
            @(negedge clk_i);
        end
        alu_we_i = 1'b0;
        if (addr != '0) begin
            shadow[addr] = data;
        end
    endtask

    task automatic drain_results();
        logic empty;
        empty = 1'b0;
        while (!empty) begin
            #SAMPLE_DELAY;
            empty = exp_q.size() == 0;
            @(negedge clk_i);
        end
    endtask

    task automatic check_register(input reg_addr_t addr, input word_t expected);
        rd_addr_i = addr;
        #SAMPLE_DELAY;
        check_value($sformatf("rd_data_o x%0d", addr), expected, rd_data_o);
        @(negedge clk_i);
    endtask

    task automatic finish_test();
        $display("test %s: %0d checks, %0d errors", test_name, test_checks, test_errors);
        test_count++;
        test_checks = 0;
        test_errors = 0;
    endtask

    task automatic run_cases(input int fd);
        logic [8*96-1:0]  line_buf;
        logic [7:0]       kind;
        logic [TOK_W-1:0] tok;
        int               a1;
        int               a2;
        int               a3;
        word_t            value;
        while (!$feof(fd)) begin
            line_buf = '0;
            kind     = '0;
            if ($fgets(line_buf, fd) != 0) begin
                void'($sscanf(line_buf, "%s %s", kind, tok));
                case (kind)
                    "T": begin
                        drain_results();
                        finish_test();
                        test_name = $sformatf("%0s", tok);
                    end
                    "A", "R": begin
                        void'($sscanf(line_buf, "%s %d %s", kind, a1, tok));
                        void'($sscanf(line_buf, "%s %d %h", kind, a1, value));
                        if (kind == "A") begin
                            alu_write(reg_addr_t'(a1),
                                      (tok == TOK_W'("rand")) ? $urandom : value);
                        end else begin
                            drain_results();
                            check_register(reg_addr_t'(a1),
                                           (tok == TOK_W'("*")) ? shadow[a1] : value);
                        end
                    end
                    "M": begin
                        void'($sscanf(line_buf, "%s %s %d %d %d", kind, tok, a1, a2, a3));
                        case (tok)
                            TOK_W'("MUL"):    issue_mul(MUL, a1[4:0], a2[4:0], a3[4:0]);
                            TOK_W'("MULH"):   issue_mul(MULH, a1[4:0], a2[4:0], a3[4:0]);
                            TOK_W'("MULHSU"): issue_mul(MULHSU, a1[4:0], a2[4:0], a3[4:0]);
                            TOK_W'("MULHU"):  issue_mul(MULHU, a1[4:0], a2[4:0], a3[4:0]);
                            default: report_error($sformatf("unknown operation %0s", tok));
                        endcase
                    end
                    "W": begin
                        void'($sscanf(line_buf, "%s %d", kind, a1));
                        repeat (a1) @(negedge clk_i);
                    end
                    "#", 8'h00: begin
                    end
                    default: report_error($sformatf("unknown action %s in case file", kind));
                endcase
            end
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        int               fd;
        int               line_count;
        logic [8*96-1:0]  line_buf;
        clk_i       = 1'b0;
        rst_i       = 1'b1;
        valid_i     = 1'b0;
        op_i        = MUL;
        rd_i        = '0;
        rs1_i       = '0;
        rs2_i       = '0;
        alu_we_i    = 1'b0;
        alu_waddr_i = '0;
        alu_wdata_i = '0;
        rd_addr_i   = '0;
        cycle       = 0;
        cycle_limit = 0;
        checks      = 0;
        errors      = 0;
        test_checks = 0;
        test_errors = 0;
        test_count  = 0;
        test_name   = "reset_state";
        retire_due  = 1'b0;
        for (int i = 0; i < 32; i++) begin
            shadow[i] = '0;
        end
        void'($urandom(32'h3166cba2));

        // Line count sets the cycle budget
        line_count = 0;
        fd = $fopen(CASE_FILE, "r");
        if (fd != 0) begin
            while (!$feof(fd)) begin
                if ($fgets(line_buf, fd) != 0) begin
                    line_count++;
                end
            end
            $fclose(fd);
            cycle_limit = line_count * (NUM_STEPS + 4) + 100;
            fd = $fopen(CASE_FILE, "r");
        end

        repeat (RESET_CYCLES) @(negedge clk_i);
        rst_i = 1'b0;
        #SAMPLE_DELAY;
        check_value("stall_o", '0, word_t'(stall_o));
        check_value("wb_stall_o", '0, word_t'(wb_stall_o));
        check_value("result_valid_o", '0, word_t'(result_valid_o));
        @(negedge clk_i);
        for (int r = 0; r < 32; r++) begin
            check_register(reg_addr_t'(r), '0);
        end

        if (fd == 0) begin
            report_error($sformatf("could not open case file %s", CASE_FILE));
        end else begin
            run_cases(fd);
            $fclose(fd);
        end
        drain_results();
        finish_test();

        $display("tests %0d, checks %0d, errors %0d", test_count, checks, errors);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule : tb_mext_core

`default_nettype wire

// File: mext_core.sv
`timescale 1ns/1ns
`default_nettype none

module mext_core
    import mext_pkg::*;
#(
    parameter int NUM_STEPS = 4
) (
    input  logic      clk_i,
    input  logic      rst_i,

    // Issue
    input  logic      valid_i,
    input  mext_op_e  op_i,
    input  reg_addr_t rd_i,
    input  reg_addr_t rs1_i,
    input  reg_addr_t rs2_i,
    output logic      stall_o,

    // ALU writeback
    input  logic      alu_we_i,
    input  reg_addr_t alu_waddr_i,
    input  word_t     alu_wdata_i,
    output logic      wb_stall_o,

    // Architectural read port
    input  reg_addr_t rd_addr_i,
    output word_t     rd_data_o,

    // Retiring multiply
    output logic      result_valid_o,
    output reg_addr_t result_rd_o,
    output word_t     result_data_o
);

    ////////////////////////////////////////////////////////////////////////////
    // Pipeline wiring
    ////////////////////////////////////////////////////////////////////////////

    // Entry 0 is the issue register, entry k+1 the register of step k.
    // The whole array doubles as the scoreboard view.
    mext_stage_t stage [NUM_STEPS+1];

    reg_addr_t   rf_raddr_a;
    reg_addr_t   rf_raddr_b;
    word_t       rf_a;
    word_t       rf_b;
    rf_wr_t      rf_wr;
    rf_wr_t      bypass;

    mext_issue #(
        .NUM_STEPS (NUM_STEPS)
    ) u_issue (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .valid_i      (valid_i),
        .op_i         (op_i),
        .rd_i         (rd_i),
        .rs1_i        (rs1_i),
        .rs2_i        (rs2_i),
        .rf_raddr_a_o (rf_raddr_a),
        .rf_raddr_b_o (rf_raddr_b),
        .rf_a_i       (rf_a),
        .rf_b_i       (rf_b),
        .busy_i       (stage),
        .bypass_i     (bypass),
        .stall_o      (stall_o),
        .stage_o      (stage[0])
    );

    for (genvar k = 0; k < NUM_STEPS; k++) begin : g_step
        mext_mul_step #(
            .NUM_STEPS (NUM_STEPS),
            .STEP_IDX  (k)
        ) u_step (
            .clk_i   (clk_i),
            .rst_i   (rst_i),
            .stage_i (stage[k]),
            .stage_o (stage[k+1])
        );
    end

    mext_retire #(
        .NUM_STEPS (NUM_STEPS)
    ) u_retire (
        .clk_i          (clk_i),
        .rst_i          (rst_i),
        .stage_i        (stage[NUM_STEPS]),
        .alu_we_i       (alu_we_i),
        .alu_waddr_i    (alu_waddr_i),
        .alu_wdata_i    (alu_wdata_i),
        .wb_stall_o     (wb_stall_o),
        .rf_wr_o        (rf_wr),
        .bypass_o       (bypass),
        .result_valid_o (result_valid_o),
        .result_rd_o    (result_rd_o),
        .result_data_o  (result_data_o)
    );

    mext_regfile u_regfile (
        .clk_i     (clk_i),
        .rst_i     (rst_i),
        .wr_i      (rf_wr),
        .raddr_a_i (rf_raddr_a),
        .raddr_b_i (rf_raddr_b),
        .raddr_x_i (rd_addr_i),
        .rdata_a_o (rf_a),
        .rdata_b_o (rf_b),
        .rdata_x_o (rd_data_o)
    );

endmodule : mext_core

`default_nettype wire

// File: mext_regfile.sv
`timescale 1ns/1ns
`default_nettype none

module mext_regfile
    import mext_pkg::*;
(
    input  logic      clk_i,
    input  logic      rst_i,

    input  rf_wr_t    wr_i,

    input  reg_addr_t raddr_a_i,
    input  reg_addr_t raddr_b_i,
    input  reg_addr_t raddr_x_i,
    output word_t     rdata_a_o,
    output word_t     rdata_b_o,
    output word_t     rdata_x_o
);

    // x0 has no storage
    word_t regs [31:1];

    function automatic word_t read_reg(input reg_addr_t addr);
        if (addr == '0) begin
            return '0;
        end
        return regs[addr];
    endfunction

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_i.we && wr_i.addr != '0) begin
            regs[wr_i.addr] <= wr_i.data;
        end
    end

    // Combinational reads
    assign rdata_a_o = read_reg(raddr_a_i);
    assign rdata_b_o = read_reg(raddr_b_i);
    assign rdata_x_o = read_reg(raddr_x_i);

endmodule : mext_regfile

`default_nettype wire

// File: mext_retire.sv
`timescale 1ns/1ns
`default_nettype none

module mext_retire
    import mext_pkg::*;
#(
    parameter int NUM_STEPS = 4
) (
    input  logic        clk_i,
    input  logic        rst_i,

    // Last step
    input  mext_stage_t stage_i,

    // ALU writeback
    input  logic        alu_we_i,
    input  reg_addr_t   alu_waddr_i,
    input  word_t       alu_wdata_i,
    output logic        wb_stall_o,

    output rf_wr_t      rf_wr_o,
    output rf_wr_t      bypass_o,

    output logic        result_valid_o,
    output reg_addr_t   result_rd_o,
    output word_t       result_data_o
);

    // Weight of the sign bit of b, one position past the last digit
    localparam int B_WIDTH = NUM_STEPS * (32 / NUM_STEPS);

    dword_t    product;
    word_t     res_d;
    logic      res_valid_q;
    reg_addr_t res_rd_q;
    word_t     res_data_q;
    rf_wr_t    alu_wr;

    ////////////////////////////////////////////////////////////////////////////
    // Sign correction and word select
    ////////////////////////////////////////////////////////////////////////////

    // b was taken as unsigned, so a negative b over-counts by a * 2^32
    assign product = stage_i.b_neg ? stage_i.acc - (stage_i.a_ext << B_WIDTH) : stage_i.acc;
    assign res_d   = (stage_i.op == MUL) ? product[31:0] : product[63:32];

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            res_valid_q <= 1'b0;
        end else begin
            res_valid_q <= stage_i.valid;
        end
    end

    always_ff @(posedge clk_i) begin
        res_rd_q   <= stage_i.rd;
        res_data_q <= res_d;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Writeback merge
    ////////////////////////////////////////////////////////////////////////////

    assign result_valid_o = res_valid_q;
    assign result_rd_o    = res_rd_q;
    assign result_data_o  = res_data_q;

    assign bypass_o = '{we: res_valid_q, addr: res_rd_q, data: res_data_q};
    assign alu_wr   = '{we: alu_we_i, addr: alu_waddr_i, data: alu_wdata_i};

    // Multiply owns the port, ALU holds its write meanwhile
    assign wb_stall_o = res_valid_q;
    assign rf_wr_o    = res_valid_q ? bypass_o : alu_wr;

endmodule : mext_retire

`default_nettype wire

// File: mext_mul_step.sv
`timescale 1ns/1ns
`default_nettype none

module mext_mul_step
    import mext_pkg::*;
#(
    parameter int NUM_STEPS = 4,
    parameter int STEP_IDX  = 0
) (
    input  logic        clk_i,
    input  logic        rst_i,

    input  mext_stage_t stage_i,
    output mext_stage_t stage_o
);

    localparam int DIGIT_W = 32 / NUM_STEPS;
    localparam int SHIFT   = STEP_IDX * DIGIT_W;

    logic [DIGIT_W-1:0] digit;
    dword_t             partial;
    mext_stage_t        stage_d;
    mext_stage_t        stage_q;

    // Unsigned digit of b owned by this step
    assign digit   = stage_i.b_low[SHIFT +: DIGIT_W];
    assign partial = stage_i.a_ext * dword_t'(digit);

    always_comb begin
        stage_d     = stage_i;
        stage_d.acc = stage_i.acc + (partial << SHIFT);
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            stage_q.valid <= 1'b0;
        end else begin
            stage_q <= stage_d;
        end
    end

    assign stage_o = stage_q;

endmodule : mext_mul_step

`default_nettype wire

// File: mext_issue.sv
`timescale 1ns/1ns
`default_nettype none

module mext_issue
    import mext_pkg::*;
#(
    parameter int NUM_STEPS = 4
) (
    input  logic        clk_i,
    input  logic        rst_i,

    // Decoded issue
    input  logic        valid_i,
    input  mext_op_e    op_i,
    input  reg_addr_t   rd_i,
    input  reg_addr_t   rs1_i,
    input  reg_addr_t   rs2_i,

    // Register file read
    output reg_addr_t   rf_raddr_a_o,
    output reg_addr_t   rf_raddr_b_o,
    input  word_t       rf_a_i,
    input  word_t       rf_b_i,

    // Entries still producing a result, and the retiring one
    input  mext_stage_t busy_i [NUM_STEPS+1],
    input  rf_wr_t      bypass_i,

    output logic        stall_o,
    output mext_stage_t stage_o
);

    logic        hazard_a;
    logic        hazard_b;
    word_t       op_a;
    word_t       op_b;
    mext_stage_t stage_d;
    mext_stage_t stage_q;

    assign rf_raddr_a_o = rs1_i;
    assign rf_raddr_b_o = rs2_i;

    ////////////////////////////////////////////////////////////////////////////
    // Scoreboard
    ////////////////////////////////////////////////////////////////////////////

    // x0 is never produced, so it never blocks
    always_comb begin
        hazard_a = 1'b0;
        hazard_b = 1'b0;
        for (int i = 0; i <= NUM_STEPS; i++) begin
            if (busy_i[i].valid && busy_i[i].rd == rs1_i && rs1_i != '0) begin
                hazard_a = 1'b1;
            end
            if (busy_i[i].valid && busy_i[i].rd == rs2_i && rs2_i != '0) begin
                hazard_b = 1'b1;
            end
        end
    end

    assign stall_o = valid_i && (hazard_a || hazard_b);

    // Retiring result is one cycle ahead of the register file
    assign op_a = (bypass_i.we && bypass_i.addr == rs1_i && rs1_i != '0) ? bypass_i.data : rf_a_i;
    assign op_b = (bypass_i.we && bypass_i.addr == rs2_i && rs2_i != '0) ? bypass_i.data : rf_b_i;

    ////////////////////////////////////////////////////////////////////////////
    // Operand extension and first stage
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        stage_d.valid = valid_i && !stall_o;
        stage_d.op    = op_i;
        stage_d.rd    = rd_i;
        case (op_i)
            MULH, MULHSU: stage_d.a_ext = {{32{op_a[31]}}, op_a};
            default:      stage_d.a_ext = {32'b0, op_a};
        endcase
        // b runs unsigned through the steps, retire fixes a negative b
        stage_d.b_low = op_b;
        stage_d.b_neg = (op_i == MULH) && op_b[31];
        stage_d.acc   = '0;
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            stage_q.valid <= 1'b0;
        end else begin
            stage_q <= stage_d;
        end
    end

    assign stage_o = stage_q;

endmodule : mext_issue

`default_nettype wire

// File: mext_pkg.sv
`default_nettype none

package mext_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Widths
    ////////////////////////////////////////////////////////////////////////////

    // Architectural word
    typedef logic [31:0] word_t;

    // Extended operand and product accumulator
    typedef logic [63:0] dword_t;

    // Register index
    typedef logic [4:0]  reg_addr_t;

    ////////////////////////////////////////////////////////////////////////////
    // Operations
    ////////////////////////////////////////////////////////////////////////////

    typedef enum logic [1:0] {
        MUL,
        MULH,
        MULHSU,
        MULHU
    } mext_op_e;

    ////////////////////////////////////////////////////////////////////////////
    // Pipeline payloads
    ////////////////////////////////////////////////////////////////////////////

    // One multiply in flight between two pipeline registers
    typedef struct packed {
        logic      valid;
        mext_op_e  op;
        reg_addr_t rd;
        dword_t    a_ext;
        word_t     b_low;
        logic      b_neg;
        dword_t    acc;
    } mext_stage_t;

    // One register-file write
    typedef struct packed {
        logic      we;
        reg_addr_t addr;
        word_t     data;
    } rf_wr_t;

endpackage : mext_pkg

`default_nettype wire
